// ==== include/frame_buffer_defs.svh ====
`ifndef FRAME_BUFFER_DEFS_SVH
`define FRAME_BUFFER_DEFS_SVH

// horizontal timing in pixel periods, active area first
`define H_ACTIVE 16
`define H_FRONT 2
`define H_SYNC 3
`define H_BACK 3
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical timing in lines
`define V_ACTIVE 8
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 1
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// coordinate widths, visible sizes are powers of two
`define X_W 4
`define Y_W 3

`define SRAM_AW 18 // word address
`define SRAM_DW 16

// host port address map
`define AVS_AW 9
`define AVS_REG_BIT 8 // set selects register space
`define REG_CTRL_ADDR 256

`endif

// ==== rtl/video_pkg.sv ====
`include "frame_buffer_defs.svh"

package video_pkg;

    typedef logic [`SRAM_AW-1:0] sram_addr_t;
    typedef logic [`SRAM_DW-1:0] sram_data_t;

    // r in 11:8, g in 7:4, b in 3:0
    typedef logic [11:0] rgb_t;

    // y above x, also the frame buffer word address
    typedef logic [`Y_W+`X_W-1:0] pix_index_t;

    typedef logic [`AVS_AW-1:0] avs_addr_t;

    // arbiter slot, one per clock
    typedef enum logic {
        SLOT_READ,
        SLOT_WRITE
    } slot_e;

endpackage

// ==== rtl/frame_buffer_reg_decode.sv ====
`timescale 1ns/1ps
`include "frame_buffer_defs.svh"

module frame_buffer_reg_decode
    import video_pkg::*;
(
    input  logic        sys_clk,
    input  logic        reset,

    // host write port
    input  avs_addr_t   avs_address,
    input  logic        avs_write,
    input  logic [31:0] avs_writedata,

    // pending pixel write towards the arbiter
    input  logic        wr_done,
    output logic        wr_pending,
    output pix_index_t  wr_index,
    output rgb_t        wr_color,

    // control register
    output logic        disp_enable,
    output rgb_t        disp_color
);

    logic pix_wr;
    logic ctrl_wr;

    assign pix_wr  = avs_write && !avs_address[`AVS_REG_BIT];
    assign ctrl_wr = avs_write && (avs_address == avs_addr_t'(`REG_CTRL_ADDR));

    // one entry pending buffer, a new write overrides a retiring one
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            wr_pending <= 1'b0;
        end else if (pix_wr) begin
            wr_pending <= 1'b1;
        end else if (wr_done) begin
            wr_pending <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (pix_wr) begin
            wr_index <= avs_address[$bits(pix_index_t)-1:0]; // {y, x}
            wr_color <= avs_writedata[$bits(rgb_t)-1:0];
        end
    end

    // other register addresses fall through untouched
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            disp_enable <= 1'b0;
            disp_color  <= '0;
        end else if (ctrl_wr) begin
            disp_enable <= avs_writedata[0];
            disp_color  <= avs_writedata[12:1];
        end
    end

endmodule

// ==== rtl/vga_timing_gen.sv ====
`timescale 1ns/1ps
`include "frame_buffer_defs.svh"

module vga_timing_gen (
    input  logic            sys_clk,
    input  logic            reset,
    output logic            pix_ce,
    output logic [`X_W-1:0] pix_x,
    output logic [`Y_W-1:0] pix_y,
    output logic            active,
    output logic            hsync,
    output logic            vsync
);

    localparam int HC_W = $clog2(`H_TOTAL);
    localparam int VC_W = $clog2(`V_TOTAL);

    localparam logic [HC_W-1:0] H_LAST   = HC_W'(`H_TOTAL - 1);
    localparam logic [HC_W-1:0] H_VIS    = HC_W'(`H_ACTIVE);
    localparam logic [HC_W-1:0] HS_START = HC_W'(`H_ACTIVE + `H_FRONT);
    localparam logic [HC_W-1:0] HS_END   = HC_W'(`H_ACTIVE + `H_FRONT + `H_SYNC);

    localparam logic [VC_W-1:0] V_LAST   = VC_W'(`V_TOTAL - 1);
    localparam logic [VC_W-1:0] V_VIS    = VC_W'(`V_ACTIVE);
    localparam logic [VC_W-1:0] VS_START = VC_W'(`V_ACTIVE + `V_FRONT);
    localparam logic [VC_W-1:0] VS_END   = VC_W'(`V_ACTIVE + `V_FRONT + `V_SYNC);

    logic [HC_W-1:0] h_cnt;
    logic [VC_W-1:0] v_cnt;
    logic            h_wrap;
    logic            v_wrap;

    // first pixel period begins one clock after reset is released
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            pix_ce <= 1'b0;
        end else begin
            pix_ce <= ~pix_ce;
        end
    end

    assign h_wrap = (h_cnt == H_LAST);
    assign v_wrap = (v_cnt == V_LAST);

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pix_ce) begin
            h_cnt <= h_wrap ? '0 : h_cnt + 1'b1;
            if (h_wrap) begin
                v_cnt <= v_wrap ? '0 : v_cnt + 1'b1;
            end
        end
    end

    // visible coords just wrap outside the window, active qualifies them
    assign pix_x = h_cnt[`X_W-1:0];
    assign pix_y = v_cnt[`Y_W-1:0];

    assign active = (h_cnt < H_VIS) && (v_cnt < V_VIS);
    assign hsync  = !((h_cnt >= HS_START) && (h_cnt < HS_END)); // active low
    assign vsync  = !((v_cnt >= VS_START) && (v_cnt < VS_END));

endmodule

// ==== rtl/sram_port_arbiter.sv ====
`timescale 1ns/1ps
`include "frame_buffer_defs.svh"

module sram_port_arbiter
    import video_pkg::*;
(
    input  logic                   sys_clk,
    input  logic                   reset,

    // raster position from the timing generator
    input  logic                   pix_ce,
    input  logic [`X_W-1:0]        pix_x,
    input  logic [`Y_W-1:0]        pix_y,
    input  logic                   active,
    input  logic                   hsync,
    input  logic                   vsync,

    // pending host write
    input  logic                   wr_pending,
    input  pix_index_t             wr_index,
    input  rgb_t                   wr_color,
    output logic                   wr_done,

    // read word plus the raster flags of that pixel
    output logic                   rd_valid,
    output sram_data_t             rd_data,
    output logic                   rd_active,
    output logic                   rd_hsync,
    output logic                   rd_vsync,

    // sram pins
    output logic                   sram_ce_n,
    output logic                   sram_oe_n,
    output logic                   sram_we_n,
    output logic [`SRAM_DW/8-1:0]  sram_be_n,
    output sram_addr_t             sram_addr,
    inout  wire sram_data_t        sram_dq
);

    slot_e      slot;
    logic       rd_slot;
    logic       do_write;
    pix_index_t rd_index;

    // clocks are paired, the pix_ce half belongs to the display
    assign slot     = pix_ce ? SLOT_READ : SLOT_WRITE;
    assign rd_slot  = (slot == SLOT_READ);
    assign do_write = (slot == SLOT_WRITE) && wr_pending;
    assign wr_done  = do_write;

    assign rd_index = {pix_y, pix_x};

    assign sram_ce_n = !(rd_slot || do_write);
    assign sram_oe_n = !rd_slot;
    assign sram_we_n = !do_write;
    assign sram_be_n = do_write ? '0 : '1; // both bytes on a write
    assign sram_addr = rd_slot ? sram_addr_t'(rd_index) : sram_addr_t'(wr_index);

    // upper nibble written as zero
    assign sram_dq = do_write ? sram_data_t'(wr_color) : 'z;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            rd_valid  <= 1'b0;
            rd_active <= 1'b0;
            rd_hsync  <= 1'b1;
            rd_vsync  <= 1'b1;
        end else begin
            rd_valid <= rd_slot;
            if (rd_slot) begin
                rd_active <= active;
                rd_hsync  <= hsync;
                rd_vsync  <= vsync;
            end
        end
    end

    // sample at the end of the read slot
    always_ff @(posedge sys_clk) begin
        if (rd_slot) begin
            rd_data <= sram_dq;
        end
    end

endmodule

// ==== rtl/pixel_output_stage.sv ====
`timescale 1ns/1ps

module pixel_output_stage
    import video_pkg::*;
(
    input  logic        sys_clk,
    input  logic        reset,

    input  logic        rd_valid,
    input  sram_data_t  rd_data,
    input  logic        rd_active,
    input  logic        rd_hsync,
    input  logic        rd_vsync,

    input  logic        disp_enable,
    input  rgb_t        disp_color,

    // vga pins
    output logic [3:0]  vga_r,
    output logic [3:0]  vga_g,
    output logic [3:0]  vga_b,
    output logic        vga_hsync,
    output logic        vga_vsync
);

    rgb_t pix_color;

    always_comb begin
        if (!rd_active) begin
            pix_color = '0; // blanking
        end else if (disp_enable) begin
            pix_color = rd_data[$bits(rgb_t)-1:0];
        end else begin
            pix_color = disp_color;
        end
    end

    // colour and syncs share one register stage
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
        end else if (rd_valid) begin
            vga_r     <= pix_color[11:8];
            vga_g     <= pix_color[7:4];
            vga_b     <= pix_color[3:0];
            vga_hsync <= rd_hsync;
            vga_vsync <= rd_vsync;
        end
    end

endmodule

// ==== rtl/video_frame_buffer_sram.sv ====
`timescale 1ns/1ps
`include "frame_buffer_defs.svh"

module video_frame_buffer_sram
    import video_pkg::*;
(
    input  logic                   sys_clk,
    input  logic                   reset,

    // host write port
    input  avs_addr_t              avs_address,
    input  logic                   avs_write,
    input  logic [31:0]            avs_writedata,

    // sram pins
    output logic                   sram_ce_n,
    output logic                   sram_oe_n,
    output logic                   sram_we_n,
    output logic [`SRAM_DW/8-1:0]  sram_be_n,
    output sram_addr_t             sram_addr,
    inout  wire sram_data_t        sram_dq,

    // vga pins
    output logic [3:0]             vga_r,
    output logic [3:0]             vga_g,
    output logic [3:0]             vga_b,
    output logic                   vga_hsync,
    output logic                   vga_vsync
);

    logic            wr_pending;
    logic            wr_done;
    pix_index_t      wr_index;
    rgb_t            wr_color;
    logic            disp_enable;
    rgb_t            disp_color;

    logic            pix_ce;
    logic [`X_W-1:0] pix_x;
    logic [`Y_W-1:0] pix_y;
    logic            active;
    logic            hsync;
    logic            vsync;

    logic            rd_valid;
    sram_data_t      rd_data;
    logic            rd_active;
    logic            rd_hsync;
    logic            rd_vsync;

    frame_buffer_reg_decode u_reg_decode (
        .sys_clk       (sys_clk),
        .reset         (reset),
        .avs_address   (avs_address),
        .avs_write     (avs_write),
        .avs_writedata (avs_writedata),
        .wr_done       (wr_done),
        .wr_pending    (wr_pending),
        .wr_index      (wr_index),
        .wr_color      (wr_color),
        .disp_enable   (disp_enable),
        .disp_color    (disp_color)
    );

    vga_timing_gen u_timing_gen (
        .sys_clk (sys_clk),
        .reset   (reset),
        .pix_ce  (pix_ce),
        .pix_x   (pix_x),
        .pix_y   (pix_y),
        .active  (active),
        .hsync   (hsync),
        .vsync   (vsync)
    );

    sram_port_arbiter u_sram_arbiter (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .pix_ce     (pix_ce),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .active     (active),
        .hsync      (hsync),
        .vsync      (vsync),
        .wr_pending (wr_pending),
        .wr_index   (wr_index),
        .wr_color   (wr_color),
        .wr_done    (wr_done),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .rd_active  (rd_active),
        .rd_hsync   (rd_hsync),
        .rd_vsync   (rd_vsync),
        .sram_ce_n  (sram_ce_n),
        .sram_oe_n  (sram_oe_n),
        .sram_we_n  (sram_we_n),
        .sram_be_n  (sram_be_n),
        .sram_addr  (sram_addr),
        .sram_dq    (sram_dq)
    );

    pixel_output_stage u_pixel_out (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .rd_active   (rd_active),
        .rd_hsync    (rd_hsync),
        .rd_vsync    (rd_vsync),
        .disp_enable (disp_enable),
        .disp_color  (disp_color),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync)
    );

endmodule

// ==== testbench/sram_model.sv ====
`timescale 1ns/1ps
`include "frame_buffer_defs.svh"

module sram_model
    import video_pkg::*;
(
    input  logic                  ce_n,
    input  logic                  oe_n,
    input  logic                  we_n,
    input  logic [`SRAM_DW/8-1:0] be_n,
    input  sram_addr_t            addr,
    inout  wire sram_data_t       dq
);

    localparam int DEPTH = 1 << `SRAM_AW;

    sram_data_t mem [0:DEPTH-1];

    // read path follows the address, no clock
    assign dq = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

    // address and data are stable for the whole write strobe,
    // so take them once the strobe has settled
    always @(negedge we_n) begin
        #1;
        if (!we_n && !ce_n) begin
            for (int b = 0; b < `SRAM_DW/8; b++) begin
                if (!be_n[b]) begin
                    mem[addr][b*8 +: 8] = dq[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== testbench/tb_video_frame_buffer_sram.sv ====
`timescale 1ns/1ps
`include "frame_buffer_defs.svh"

module tb_video_frame_buffer_sram
    import video_pkg::*;
();

    localparam int PIXELS          = 1 << (`X_W + `Y_W);
    localparam int FRAME_CLOCKS    = `H_TOTAL * `V_TOTAL * 2;
    localparam int WATCHDOG_CLOCKS = 24 * FRAME_CLOCKS + 1000;
    localparam int HS_START        = `H_ACTIVE + `H_FRONT;
    localparam int VS_START        = `V_ACTIVE + `V_FRONT;

    logic                  sys_clk;
    logic                  reset;
    avs_addr_t             avs_address;
    logic                  avs_write;
    logic [31:0]           avs_writedata;
    logic                  sram_ce_n;
    logic                  sram_oe_n;
    logic                  sram_we_n;
    logic [`SRAM_DW/8-1:0] sram_be_n;
    sram_addr_t            sram_addr;
    wire [`SRAM_DW-1:0]    sram_dq;
    logic [3:0]            vga_r;
    logic [3:0]            vga_g;
    logic [3:0]            vga_b;
    logic                  vga_hsync;
    logic                  vga_vsync;

    // reference model of frame buffer and control register
    rgb_t        image [0:PIXELS-1];
    logic        dirty [0:PIXELS-1]; // rewritten and not yet settled
    logic [31:0] ctrl_model;
    logic        color_check_on;

    // raster tracking
    logic        locked     = 1'b0;
    logic        half       = 1'b0;
    logic        prev_vsync = 1'b1;
    int          h_pos      = 0;
    int          v_pos      = 0;
    int          frame_cnt  = 0;

    int          check_count = 0;
    int          error_count = 0;

    video_frame_buffer_sram i_video_frame_buffer_sram (
        .sys_clk       (sys_clk),
        .reset         (reset),
        .avs_address   (avs_address),
        .avs_write     (avs_write),
        .avs_writedata (avs_writedata),
        .sram_ce_n     (sram_ce_n),
        .sram_oe_n     (sram_oe_n),
        .sram_we_n     (sram_we_n),
        .sram_be_n     (sram_be_n),
        .sram_addr     (sram_addr),
        .sram_dq       (sram_dq),
        .vga_r         (vga_r),
        .vga_g         (vga_g),
        .vga_b         (vga_b),
        .vga_hsync     (vga_hsync),
        .vga_vsync     (vga_vsync)
    );

    sram_model u_sram (
        .ce_n (sram_ce_n),
        .oe_n (sram_oe_n),
        .we_n (sram_we_n),
        .be_n (sram_be_n),
        .addr (sram_addr),
        .dq   (sram_dq)
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at x %0d line %0d",
                     name, got, expected, h_pos, v_pos);
        end
    endtask

    task automatic print_summary();
        $display("checks: %0d, errors: %0d", check_count, error_count);
    endtask

    task automatic check_pixel();
        pix_index_t idx;
        logic       exp_hsync;
        logic       exp_vsync;
        rgb_t       exp_color;
        logic       skip;
        exp_hsync = !(h_pos >= HS_START && h_pos < HS_START + `H_SYNC);
        exp_vsync = !(v_pos >= VS_START && v_pos < VS_START + `V_SYNC);
        compare_value("vga_hsync", vga_hsync, exp_hsync);
        compare_value("vga_vsync", vga_vsync, exp_vsync);
        if (color_check_on) begin
            idx       = {v_pos[`Y_W-1:0], h_pos[`X_W-1:0]};
            skip      = 1'b0;
            exp_color = '0; // blanking
            if (h_pos < `H_ACTIVE && v_pos < `V_ACTIVE) begin
                if (!ctrl_model[0]) begin
                    exp_color = ctrl_model[12:1];
                end else if (dirty[idx]) begin
                    skip = 1'b1;
                end else begin
                    exp_color = image[idx];
                end
            end
            if (!skip) begin
                compare_value("{vga_r,vga_g,vga_b}", {vga_r, vga_g, vga_b}, exp_color);
            end
        end
    endtask

    // write strobe uses both bytes, idle strobes are high with the bus released
    task automatic check_sram_strobes();
        if (!sram_we_n) begin
            compare_value("sram_ce_n", sram_ce_n, 1'b0);
            compare_value("sram_oe_n", sram_oe_n, 1'b1);
            compare_value("sram_be_n", sram_be_n, '0);
        end else if (!sram_oe_n) begin
            compare_value("sram_ce_n", sram_ce_n, 1'b0); // read slot
        end else begin
            compare_value("sram_ce_n", sram_ce_n, 1'b1);
            compare_value("sram_dq", sram_dq, sram_data_t'('z));
        end
    endtask

    task automatic advance_raster();
        h_pos++;
        if (h_pos == `H_TOTAL) begin
            h_pos = 0;
            v_pos++;
            if (v_pos == `V_TOTAL) begin
                v_pos = 0;
            end
        end
        if (h_pos == 0 && v_pos == VS_START) begin
            frame_cnt++; // frames counted from the vsync start
        end
    endtask

    // pins move every second clock, sample mid-cycle on the first clock
    // of each pixel period. lock once on vsync falling, then any wrong
    // sync edge shows up as a value mismatch
    always @(negedge sys_clk) begin
        if (reset) begin
            locked = 1'b0;
        end else if (!locked) begin
            if (!vga_vsync && prev_vsync) begin
                locked = 1'b1;
                half   = 1'b0;
                h_pos  = 0;
                v_pos  = VS_START;
                check_pixel();
            end
        end else begin
            half = ~half;
            if (!half) begin
                advance_raster();
                check_pixel();
            end
        end
        prev_vsync = vga_vsync;
    end

    initial begin
        @(posedge sys_clk);
        forever begin
            @(negedge sys_clk);
            check_sram_strobes();
        end
    end

    task automatic host_write(input avs_addr_t addr, input logic [31:0] data);
        @(posedge sys_clk);
        avs_address   <= addr;
        avs_write     <= 1'b1;
        avs_writedata <= data;
        @(posedge sys_clk);
        avs_write     <= 1'b0;
    endtask

    // gap is strobe to strobe in clocks
    task automatic pixel_write(input pix_index_t idx, input logic [31:0] data,
                               input int gap);
        host_write(avs_addr_t'(idx), data);
        image[idx] = data[11:0];
        dirty[idx] = 1'b1;
        repeat (gap - 2) @(posedge sys_clk);
    endtask

    task automatic wait_frame_start();
        int start;
        start = frame_cnt;
        while (frame_cnt == start) @(posedge sys_clk);
    endtask

    // new control value is only checked from the next frame on
    task automatic write_ctrl(input logic [31:0] data);
        color_check_on = 1'b0;
        host_write(avs_addr_t'(`REG_CTRL_ADDR), data);
        ctrl_model = data;
        wait_frame_start();
        color_check_on = 1'b1;
    endtask

    task automatic reg_space_writes(input int count);
        avs_addr_t addr;
        for (int n = 0; n < count; n++) begin
            addr = avs_addr_t'(`REG_CTRL_ADDR + $urandom_range(1, 255));
            host_write(addr, $urandom());
            repeat ($urandom_range(0, 3)) @(posedge sys_clk);
        end
    endtask

    task automatic clear_dirty();
        for (int i = 0; i < PIXELS; i++) begin
            dirty[i] = 1'b0;
        end
    endtask

    initial begin
        logic [31:0] data;
        reset          = 1'b1;
        avs_address    = '0;
        avs_write      = 1'b0;
        avs_writedata  = '0;
        ctrl_model     = '0;
        color_check_on = 1'b1;
        clear_dirty();
        void'($urandom(32'h1db4));

        repeat (3) @(posedge sys_clk);
        reset <= 1'b0;
        while (!locked) @(posedge sys_clk);

        // one black frame straight out of reset
        repeat (2) wait_frame_start();

        // disabled display with a random colour
        data    = $urandom();
        data[0] = 1'b0;
        write_ctrl(data);
        wait_frame_start();
        reg_space_writes(16);
        wait_frame_start();

        // fill the whole buffer, then show it
        for (int i = 0; i < PIXELS; i++) begin
            pixel_write(pix_index_t'(i), $urandom(), $urandom_range(2, 5));
        end
        clear_dirty();
        data    = $urandom();
        data[0] = 1'b1;
        write_ctrl(data);
        wait_frame_start();

        // rewrites while scanning out
        for (int n = 0; n < 40; n++) begin
            pixel_write(pix_index_t'($urandom_range(0, PIXELS - 1)), $urandom(),
                        $urandom_range(2, 5));
        end
        repeat (2) @(posedge sys_clk);
        repeat (2) wait_frame_start();
        clear_dirty();
        repeat (2) wait_frame_start();
        reg_space_writes(16);
        repeat (2) wait_frame_start(); // one whole visible area after the writes

        if (check_count == 0) begin
            $display("no output was checked, the raster never locked");
            error_count++;
        end
        print_summary();
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CLOCKS) @(posedge sys_clk);
        $display("timeout: the run did not finish within %0d clocks", WATCHDOG_CLOCKS);
        print_summary();
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
rtl/video_pkg.sv
rtl/frame_buffer_reg_decode.sv
rtl/vga_timing_gen.sv
rtl/sram_port_arbiter.sv
rtl/pixel_output_stage.sv
rtl/video_frame_buffer_sram.sv
testbench/sram_model.sv
testbench/tb_video_frame_buffer_sram.sv

// ==== Bender.yml ====
package:
  name: video_frame_buffer_sram

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/video_pkg.sv
      - rtl/frame_buffer_reg_decode.sv
      - rtl/vga_timing_gen.sv
      - rtl/sram_port_arbiter.sv
      - rtl/pixel_output_stage.sv
      - rtl/video_frame_buffer_sram.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/sram_model.sv
      - testbench/tb_video_frame_buffer_sram.sv
